/* verilog/conPkg.sv */
// Fixed field layout of the COND and MAGIC microword fields; the block owns EBUS data bits 18 to 24
package conPkg;

  localparam int condWidth = 6;
  localparam int magicWidth = 9;
  localparam int ebusSlice = 7;

  // COND groups, field bits 5 to 3
  localparam logic [2:0] grpSpec = 3'd1;
  localparam logic [2:0] grpCtl = 3'd2;
  localparam logic [2:0] grpVma = 3'd3;
  localparam logic [2:0] grpSkipA = 3'd6;
  localparam logic [2:0] grpSkipB = 3'd7;

  // Diagnostic control functions, selected by diagSel
  localparam logic [2:0] clrRunCode = 3'd0;
  localparam logic [2:0] setRunCode = 3'd1;
  localparam logic [2:0] continueCode = 3'd2;
  localparam logic [2:0] irStrobeCode = 3'd4;
  localparam logic [2:0] dramStrobeCode = 3'd5;

  // Subfunctions of MAGIC function group 1
  localparam logic [2:0] conoAprCode = 3'd4;
  localparam logic [2:0] conoPiCode = 3'd5;
  localparam logic [2:0] conoPagCode = 3'd6;
  localparam logic [2:0] dataoAprCode = 3'd7;

  // MAGIC seen as a diagnostic function or as microcode state set/hold pairs
  typedef union packed {
    struct packed {
      logic [2:0] subFunc;
      logic [2:0] funcGroup;
      logic       disableFunc;
      logic       spare;
      logic       delay;
    } func;
    struct packed {
      // pair[i] is {hold, set} for state bit i
      logic [3:0][1:0] pair;
      logic            spare;
    } state;
  } magicWord;

endpackage

/* verilog/condDecode.sv */
// COND field decode; all strobes read zero while arstN is low, loadDram has one cycle of NICOND latency
`timescale 1ns/1ns

module condDecode (
  input  logic                         clk,
  input  logic                         arstN,
  input  logic [conPkg::condWidth-1:0] cond,
  input  logic                         nicond,
  input  logic                         irStrobe,
  input  logic                         dramStrobe,
  output logic                         condLoadIr,
  output logic                         condSpecInstr,
  output logic                         condSrMagic,
  output logic                         condDiagFunc,
  output logic                         condEboxState,
  output logic                         condVmaInc,
  output logic                         condVmaDec,
  output logic                         condVmaMagic,
  output logic                         skipEnA,
  output logic                         skipEnB,
  output logic                         loadIr,
  output logic                         loadDram
);
  import conPkg::*;

  logic [7:0] grpEn;
  logic [2:0] subCode;
  logic       nicondOrLoadIrQ;

  assign subCode = cond[2:0];

  // One-hot group enables, all off in reset
  always_comb begin
    grpEn = '0;
    if (arstN) begin
      grpEn[cond[5:3]] = 1'b1;
    end
  end

  assign skipEnA = grpEn[grpSkipA];
  assign skipEnB = grpEn[grpSkipB];

  // Special strobes
  assign condLoadIr = grpEn[grpSpec] & (subCode == 3'd3);
  assign condSpecInstr = grpEn[grpSpec] & (subCode == 3'd5);
  assign condSrMagic = grpEn[grpSpec] & (subCode == 3'd6);

  // Control functions
  assign condDiagFunc = grpEn[grpCtl] & (subCode == 3'd0);
  assign condEboxState = grpEn[grpCtl] & (subCode == 3'd1);

  // VMA controls, codes 3 to 7 all mean MAGIC
  assign condVmaInc = grpEn[grpVma] & (subCode == 3'd0);
  assign condVmaDec = grpEn[grpVma] & (subCode == 3'd1);
  assign condVmaMagic = grpEn[grpVma] & (subCode >= 3'd3);

  assign loadIr = condLoadIr | irStrobe;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      nicondOrLoadIrQ <= 1'b0;
    end else begin
      nicondOrLoadIrQ <= nicond | condLoadIr;
    end
  end

  assign loadDram = dramStrobe | nicondOrLoadIrQ;

endmodule

/* verilog/runControl.sv */
// RUN and START from one-cycle diagnostic strobes; run lags its request by two edges, start is a 4-cycle pulse
`timescale 1ns/1ns

module runControl (
  input  logic       clk,
  input  logic       arstN,
  input  logic       diagCtlFunc,
  input  logic [2:0] diagSel,
  output logic       irStrobe,
  output logic       dramStrobe,
  output logic       run,
  output logic       start
);
  import conPkg::*;

  logic ctlEn;
  logic clrRun;
  logic setRun;
  logic continueStb;
  logic runReq;
  logic runSync;
  logic startReq;
  logic startSync;
  logic startSeen;

  // Control strobe decode, quiet in reset
  assign ctlEn = diagCtlFunc & arstN;
  assign clrRun = ctlEn & (diagSel == clrRunCode);
  assign setRun = ctlEn & (diagSel == setRunCode);
  assign continueStb = ctlEn & (diagSel == continueCode);
  assign irStrobe = ctlEn & (diagSel == irStrobeCode);
  assign dramStrobe = ctlEn & (diagSel == dramStrobeCode);

  // RUN request and its two sync stages
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      runReq <= 1'b0;
      runSync <= 1'b0;
      run <= 1'b0;
    end else begin
      if (setRun) begin
        runReq <= 1'b1;
      end else if (clrRun) begin
        runReq <= 1'b0;
      end
      runSync <= runReq;
      run <= runSync;
    end
  end

  // START request drops once start has been seen high on two edges,
  // which stretches start to four cycles
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      startReq <= 1'b0;
      startSync <= 1'b0;
      start <= 1'b0;
      startSeen <= 1'b0;
    end else begin
      if (continueStb) begin
        startReq <= 1'b1;
      end else if (start & startSeen) begin
        startReq <= 1'b0;
      end
      startSync <= startReq;
      start <= startSync;
      startSeen <= start;
    end
  end

endmodule

/* verilog/magicFunc.sv */
// MAGIC decode for CONO PI and CONO PAG only; APR functions are ignored, ebusIn bits 5 and 6 unused
`timescale 1ns/1ns

module magicFunc (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic [conPkg::magicWidth-1:0] magic,
  input  logic                          condDiagFunc,
  input  logic                          condEboxState,
  input  logic [conPkg::ebusSlice-1:0]  ebusIn,
  output logic                          delayReq,
  output logic                          cacheLookEn,
  output logic                          cacheLoadEn,
  output logic                          pagingEn,
  output logic                          trapEn,
  output logic                          wrEvenParAdr,
  output logic                          wrEvenParData,
  output logic                          wrEvenParDir,
  output logic [3:0]                    ucodeState
);
  import conPkg::*;

  magicWord mw;
  logic     funcEn;
  logic     loadPi;
  logic     loadPag;

  assign mw = magic;

  assign delayReq = condDiagFunc & mw.func.delay;

  // Function group 1 holds the CONO and DATAO functions
  assign funcEn = condDiagFunc & ~mw.func.disableFunc & (mw.func.funcGroup == 3'd1);

  always_comb begin
    loadPi = 1'b0;
    loadPag = 1'b0;
    if (funcEn) begin
      case (mw.func.subFunc)
        conoPiCode: loadPi = 1'b1;
        conoPagCode: loadPag = 1'b1;
        // APR registers live on another board
        conoAprCode, dataoAprCode: ;
        default: ;
      endcase
    end
  end

  // CONO registers
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrEvenParAdr <= 1'b0;
      wrEvenParData <= 1'b0;
      wrEvenParDir <= 1'b0;
      cacheLookEn <= 1'b0;
      cacheLoadEn <= 1'b0;
      pagingEn <= 1'b0;
      trapEn <= 1'b0;
    end else begin
      if (loadPi) begin
        wrEvenParAdr <= ebusIn[0];
        wrEvenParData <= ebusIn[1];
        wrEvenParDir <= ebusIn[2];
      end
      if (loadPag) begin
        cacheLookEn <= ebusIn[0];
        cacheLoadEn <= ebusIn[1];
        pagingEn <= ebusIn[3];
        trapEn <= ebusIn[4];
      end
    end
  end

  // Set wins, else hold keeps, else clear
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ucodeState <= '0;
    end else if (condEboxState) begin
      for (int i = 0; i < 4; i++) begin
        ucodeState[i] <= mw.state.pair[i][0] | (mw.state.pair[i][1] & ucodeState[i]);
      end
    end
  end

endmodule

/* verilog/skipSelect.sv */
// Skip condition for the two skip groups; only subcode bits of cond select, upper bits come in as enables
`timescale 1ns/1ns

module skipSelect (
  input  logic                         user,
  input  logic                         public,
  input  logic                         userIot,
  input  logic                         irIoLegal,
  input  logic                         vmaFetch,
  input  logic                         vmaSection0,
  input  logic                         acRef,
  input  logic                         intReq,
  input  logic                         run,
  input  logic                         start,
  input  logic [conPkg::condWidth-1:0] cond,
  input  logic                         skipEnA,
  input  logic                         skipEnB,
  output logic                         skip
);

  logic       kernel;
  logic       ioLegal;
  logic [7:0] condA;
  logic [7:0] condB;
  logic [2:0] subCode;

  assign subCode = cond[2:0];

  assign kernel = ~user & ~public;
  assign ioLegal = irIoLegal | kernel | (user & userIot);

  // First skip group, index is the subcode
  assign condA = {
    1'b0,
    1'b0,
    1'b0,
    1'b0,
    public,
    user,
    kernel,
    vmaFetch
  };

  // Second skip group
  assign condB = {
    ~intReq,
    acRef,
    ~vmaSection0,
    1'b0,
    ioLegal,
    run,
    ~start,
    intReq
  };

  assign skip = (skipEnA & condA[subCode]) | (skipEnB & condB[subCode]);

endmodule

/* verilog/diagReadback.sv */
// Status readback onto EBUS bits 18 to 24; only diagSel rows 0 and 1 carry data, others read zero
`timescale 1ns/1ns

module diagReadback (
  input  logic                         diagReadFunc,
  input  logic [2:0]                   diagSel,
  input  logic                         cacheLookEn,
  input  logic                         cacheLoadEn,
  input  logic                         pagingEn,
  input  logic                         trapEn,
  input  logic                         wrEvenParAdr,
  input  logic                         wrEvenParData,
  input  logic                         wrEvenParDir,
  input  logic [3:0]                   ucodeState,
  input  logic                         run,
  input  logic                         start,
  input  logic                         delayReq,
  output logic [conPkg::ebusSlice-1:0] ebusOut,
  output logic                         ebusDrive
);
  import conPkg::*;

  logic [ebusSlice-1:0] row;

  always_comb begin
    row = '0;
    case (diagSel)
      // CONO register row
      3'd0: begin
        row = {
          wrEvenParDir,
          wrEvenParData,
          wrEvenParAdr,
          trapEn,
          pagingEn,
          cacheLoadEn,
          cacheLookEn
        };
      end
      // Microcode state and run flags
      3'd1: begin
        row = {delayReq, start, run, ucodeState};
      end
      default: row = '0;
    endcase
  end

  assign ebusDrive = diagReadFunc;
  assign ebusOut = diagReadFunc ? row : '0;

endmodule

/* verilog/conTop.sv */
// Execution box condition logic top; parity, PI and memory cycle tracking are not part of this block
`timescale 1ns/1ns

module conTop (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic [conPkg::condWidth-1:0]  cond,
  input  logic [conPkg::magicWidth-1:0] magic,
  input  logic                          nicond,
  input  logic                          diagCtlFunc,
  input  logic                          diagReadFunc,
  input  logic [2:0]                    diagSel,
  input  logic [conPkg::ebusSlice-1:0]  ebusIn,
  input  logic                          user,
  input  logic                          public,
  input  logic                          userIot,
  input  logic                          irIoLegal,
  input  logic                          vmaFetch,
  input  logic                          vmaSection0,
  input  logic                          acRef,
  input  logic                          intReq,
  output logic                          condLoadIr,
  output logic                          condSpecInstr,
  output logic                          condSrMagic,
  output logic                          condDiagFunc,
  output logic                          condEboxState,
  output logic                          condVmaInc,
  output logic                          condVmaDec,
  output logic                          condVmaMagic,
  output logic                          loadIr,
  output logic                          loadDram,
  output logic                          skip,
  output logic                          run,
  output logic                          start,
  output logic                          cacheLookEn,
  output logic                          cacheLoadEn,
  output logic                          pagingEn,
  output logic                          trapEn,
  output logic                          wrEvenParAdr,
  output logic                          wrEvenParData,
  output logic                          wrEvenParDir,
  output logic [3:0]                    ucodeState,
  output logic                          delayReq,
  output logic [conPkg::ebusSlice-1:0]  ebusOut,
  output logic                          ebusDrive
);

  logic irStrobe;
  logic dramStrobe;
  logic skipEnA;
  logic skipEnB;

  condDecode condDecode_i (.*);

  runControl runControl_i (.*);

  magicFunc magicFunc_i (.*);

  skipSelect skipSelect_i (.*);

  diagReadback diagReadback_i (.*);

endmodule

/* tb/conTop_props.sv */
// Assertions on conTop sampled at the rising edge; failures are counted in failCount for the testbench
`timescale 1ns/1ns

module conTopProps (
  input logic                          clk,
  input logic                          arstN,
  input logic [conPkg::condWidth-1:0]  cond,
  input logic [conPkg::magicWidth-1:0] magic,
  input logic                          diagReadFunc,
  input logic                          condLoadIr,
  input logic                          condDiagFunc,
  input logic                          condEboxState,
  input logic                          run,
  input logic                          start,
  input logic [3:0]                    ucodeState,
  input logic                          cacheLookEn,
  input logic                          pagingEn,
  input logic                          wrEvenParDir,
  input logic [conPkg::ebusSlice-1:0]  ebusOut,
  input logic                          ebusDrive
);
  import conPkg::*;

  magicWord mw;
  int       failCount = 0;

  assign mw = magic;

  resetClear: assert property (@(posedge clk) !arstN |-> !run && !start && ucodeState == '0
    && !cacheLookEn && !pagingEn && !wrEvenParDir && !ebusDrive)
    else begin
      failCount++;
      $error("registers not clear in reset");
    end

  strobeDecode: assert property (@(posedge clk) disable iff (!arstN)
    condLoadIr == (cond == {grpSpec, 3'd3}) && condDiagFunc == (cond == {grpCtl, 3'd0})
    && condEboxState == (cond == {grpCtl, 3'd1}))
    else begin
      failCount++;
      $error("COND strobe decode wrong");
    end

  // Set bit of pair 0 forces state bit 0
  stateSet: assert property (@(posedge clk) disable iff (!arstN)
    condEboxState && mw.state.pair[0][0] |=> ucodeState[0])
    else begin
      failCount++;
      $error("ucodeState bit 0 not set");
    end

  readbackDrive: assert property (@(posedge clk)
    ebusDrive == diagReadFunc && (diagReadFunc || ebusOut == '0))
    else begin
      failCount++;
      $error("EBUS drive wrong");
    end

endmodule

/* tb/conTb.sv */
// Seeded random run of six tests; a cycle model checks all DUT outputs on every falling edge
`timescale 1ns/1ns

module conTb;
  import conPkg::*;

  localparam int condCycles = 400;
  localparam int skipCycles = 300;
  localparam int runRounds = 20;
  localparam int startRounds = 4;
  localparam int conoRounds = 60;
  localparam int stateRounds = 100;
  localparam int testCycles = 8 + condCycles + skipCycles + runRounds * 8 + startRounds * 10
    + conoRounds * 2 + stateRounds * 2;

  logic clk;
  logic arstN;
  logic [5:0] cond;
  logic [8:0] magic;
  logic nicond;
  logic diagCtlFunc;
  logic diagReadFunc;
  logic [2:0] diagSel;
  logic [6:0] ebusIn;
  logic user, public, userIot, irIoLegal, vmaFetch, vmaSection0, acRef, intReq;
  logic condLoadIr, condSpecInstr, condSrMagic, condDiagFunc;
  logic condEboxState, condVmaInc, condVmaDec, condVmaMagic;
  logic loadIr, loadDram, skip, run, start, delayReq, ebusDrive;
  logic cacheLookEn, cacheLoadEn, pagingEn, trapEn;
  logic wrEvenParAdr, wrEvenParData, wrEvenParDir;
  logic [3:0] ucodeState;
  logic [6:0] ebusOut;

  // Model state, conoM is in diagSel 0 readback order
  logic [6:0] conoM;
  logic [3:0] ucodeM;
  logic dlyM;
  logic runReqM;
  logic [1:0] runHistM;
  logic [2:0] startCntM;

  integer seed;
  logic [31:0] rnd;
  int errCount = 0;
  int checkCount = 0;

  conTop conTop_i (.*);

  bind conTop conTopProps conTopProps_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic checkVal(input string name, input logic [7:0] got, input logic [7:0] exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("[ERROR] %0t ns %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic finishTest(input string name, input int errBefore);
    $display("Test %s finished with %0d errors", name, errCount - errBefore);
  endtask

  always @(negedge clk) begin
    logic [2:0] grp;
    logic [2:0] sub;
    logic [7:0] eStrobes;
    logic eRun;
    logic eStart;
    logic kern;
    logic ioLegal;
    logic eSkip;
    logic eDelay;
    logic [6:0] row;
    // Asynchronous reset clears the model at once
    if (!arstN) begin
      conoM = '0;
      ucodeM = '0;
      dlyM = 1'b0;
      runReqM = 1'b0;
      runHistM = '0;
      startCntM = '0;
    end
    grp = arstN ? cond[5:3] : 3'd0;
    sub = cond[2:0];
    eStrobes = {grp == 1 && sub == 3, grp == 1 && sub == 5, grp == 1 && sub == 6,
                grp == 2 && sub == 0, grp == 2 && sub == 1,
                grp == 3 && sub == 0, grp == 3 && sub == 1, grp == 3 && sub >= 3};
    eRun = runHistM[1];
    eStart = startCntM >= 3 && startCntM <= 6;
    kern = !user && !public;
    ioLegal = irIoLegal || kern || (user && userIot);
    eSkip = 1'b0;
    if (grp == 3'd6) begin
      case (sub)
        3'd0: eSkip = vmaFetch;
        3'd1: eSkip = kern;
        3'd2: eSkip = user;
        3'd3: eSkip = public;
        default: eSkip = 1'b0;
      endcase
    end else if (grp == 3'd7) begin
      case (sub)
        3'd0: eSkip = intReq;
        3'd1: eSkip = !eStart;
        3'd2: eSkip = eRun;
        3'd3: eSkip = ioLegal;
        3'd4: eSkip = 1'b0;
        3'd5: eSkip = !vmaSection0;
        3'd6: eSkip = acRef;
        default: eSkip = !intReq;
      endcase
    end
    eDelay = eStrobes[4] && magic[0];
    row = diagSel == 3'd0 ? conoM : diagSel == 3'd1 ? {eDelay, eStart, eRun, ucodeM} : 7'd0;

    checkVal("condStrobes", {condLoadIr, condSpecInstr, condSrMagic, condDiagFunc,
             condEboxState, condVmaInc, condVmaDec, condVmaMagic}, eStrobes);
    checkVal("loadIr", loadIr, eStrobes[7] | (arstN && diagCtlFunc && diagSel == 3'd4));
    checkVal("loadDram", loadDram, (arstN && diagCtlFunc && diagSel == 3'd5) | dlyM);
    checkVal("skip", skip, eSkip);
    checkVal("run", run, eRun);
    checkVal("start", start, eStart);
    checkVal("conoRegs", {wrEvenParDir, wrEvenParData, wrEvenParAdr, trapEn, pagingEn,
             cacheLoadEn, cacheLookEn}, conoM);
    checkVal("ucodeState", ucodeState, ucodeM);
    checkVal("delayReq", delayReq, eDelay);
    checkVal("ebusOut", ebusOut, diagReadFunc ? row : 7'd0);
    checkVal("ebusDrive", ebusDrive, diagReadFunc);

    // Next state from the inputs the coming edge samples
    if (arstN) begin
      dlyM = nicond | eStrobes[7];
      if (eStrobes[4] && !magic[2] && magic[5:3] == 3'd1) begin
        if (magic[8:6] == conoPiCode) begin
          conoM[6:4] = ebusIn[2:0];
        end
        if (magic[8:6] == conoPagCode) begin
          conoM[3:0] = {ebusIn[4:3], ebusIn[1:0]};
        end
      end
      if (eStrobes[3]) begin
        for (int i = 0; i < 4; i++) begin
          ucodeM[i] = magic[2*i+1] | (magic[2*i+2] & ucodeM[i]);
        end
      end
      runHistM = {runHistM[0], runReqM};
      if (diagCtlFunc && diagSel == setRunCode) begin
        runReqM = 1'b1;
      end else if (diagCtlFunc && diagSel == clrRunCode) begin
        runReqM = 1'b0;
      end
      if (startCntM != 3'd0) begin
        startCntM = startCntM == 3'd6 ? 3'd0 : startCntM + 3'd1;
      end
      if (diagCtlFunc && diagSel == continueCode) begin
        startCntM = 3'd1;
      end
    end
  end

  initial begin
    int errStart;
    seed = 32'he4e67ccd;
    arstN = 1'b0;
    cond = '0;
    magic = '0;
    nicond = 1'b0;
    diagCtlFunc = 1'b0;
    diagReadFunc = 1'b0;
    diagSel = '0;
    ebusIn = '0;
    {user, public, userIot, irIoLegal, vmaFetch, vmaSection0, acRef, intReq} = '0;
    repeat (5) @(posedge clk);
    arstN <= 1'b1;
    repeat (2) @(posedge clk);
    finishTest("reset", 0);

    errStart = errCount;
    repeat (condCycles) begin
      @(posedge clk);
      rnd = $random(seed);
      cond <= rnd[5:0];
      magic <= rnd[14:6];
      nicond <= rnd[15];
      diagCtlFunc <= rnd[16];
      diagSel <= {2'b10, rnd[17]};
      diagReadFunc <= rnd[18];
      ebusIn <= rnd[25:19];
    end
    finishTest("condDecode", errStart);

    errStart = errCount;
    repeat (skipCycles) begin
      @(posedge clk);
      rnd = $random(seed);
      cond <= {2'b11, rnd[3:0]};
      {user, public, userIot, irIoLegal, vmaFetch, vmaSection0, acRef, intReq} <= rnd[11:4];
      diagCtlFunc <= 1'b0;
    end
    finishTest("skipSelect", errStart);

    errStart = errCount;
    diagReadFunc <= 1'b1;
    repeat (runRounds) begin
      @(posedge clk);
      rnd = $random(seed);
      cond <= {3'd7, rnd[2:0]};
      diagCtlFunc <= 1'b1;
      diagSel <= {2'b00, rnd[3]};
      @(posedge clk);
      diagCtlFunc <= 1'b0;
      repeat (rnd[6:4] % 5) @(posedge clk);
    end
    repeat (startRounds) begin
      @(posedge clk);
      diagCtlFunc <= 1'b1;
      diagSel <= continueCode;
      @(posedge clk);
      diagCtlFunc <= 1'b0;
      diagSel <= 3'd1;
      repeat (8) @(posedge clk);
    end
    finishTest("runStart", errStart);

    errStart = errCount;
    repeat (conoRounds) begin
      @(posedge clk);
      rnd = $random(seed);
      cond <= {grpCtl, 3'd0};
      // Subfunctions 4 to 7, about one in four disabled
      magic <= {1'b1, rnd[1:0], 3'd1, rnd[3:2] == 2'b00, rnd[5:4]};
      ebusIn <= rnd[12:6];
      diagReadFunc <= rnd[13];
      diagSel <= 3'd0;
      @(posedge clk);
      cond <= '0;
      diagReadFunc <= 1'b1;
    end
    finishTest("conoReadback", errStart);

    errStart = errCount;
    repeat (stateRounds) begin
      @(posedge clk);
      rnd = $random(seed);
      cond <= {grpCtl, 3'd1};
      magic <= rnd[8:0];
      diagReadFunc <= rnd[9];
      diagSel <= 3'd1;
      @(posedge clk);
      cond <= '0;
      diagReadFunc <= 1'b1;
    end
    finishTest("ucodeState", errStart);

    @(posedge clk);
    errCount += conTop_i.conTopProps_i.failCount;
    $display("Tests 6, checks %0d, assertion failures %0d, errors %0d", checkCount,
             conTop_i.conTopProps_i.failCount, errCount);
    if (errCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog sized from the test lengths plus a margin
  initial begin
    #(testCycles * 10 + 2000);
    $display("Timeout, run did not finish within %0d cycles", testCycles + 200);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* flist.f */
verilog/conPkg.sv
verilog/condDecode.sv
verilog/runControl.sv
verilog/magicFunc.sv
verilog/skipSelect.sv
verilog/diagReadback.sv
verilog/conTop.sv
tb/conTop_props.sv
tb/conTb.sv

/* Makefile */
VERILATOR  ?= verilator
FLIST      := flist.f
TOP        := conTb
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log
RUN_ARGS   := +verilator+error+limit+1000
FAIL_MSG   := *** TEST FAILED ***
PASS_MSG   := *** TEST PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
